// File: weights.mem
// Output-layer weights, eight 32-bit hex words per line at consecutive addresses
// Address is {weight_case, step}; word is A5, case, then the 16-bit address
@000
A5000000 A5000001 A5000002 A5000003 A5000004 A5000005 A5000006 A5000007
A5000008 A5000009 A500000A A500000B A500000C A500000D A500000E A500000F
A5000010 A5000011 A5000012 A5000013 A5000014 A5000015 A5000016 A5000017
A5000018 A5000019 A500001A A500001B A500001C A500001D A500001E A500001F
A5000020 A5000021 A5000022 A5000023 A5000024 A5000025 A5000026 A5000027
A5000028 A5000029 A500002A A500002B A500002C A500002D A500002E A500002F
A5000030 A5000031 A5000032 A5000033 A5000034 A5000035 A5000036 A5000037
A5000038 A5000039 A500003A A500003B A500003C A500003D A500003E A500003F
@040
A5010040 A5010041 A5010042 A5010043 A5010044 A5010045 A5010046 A5010047
A5010048 A5010049 A501004A A501004B A501004C A501004D A501004E A501004F
A5010050 A5010051 A5010052 A5010053 A5010054 A5010055 A5010056 A5010057
A5010058 A5010059 A501005A A501005B A501005C A501005D A501005E A501005F
A5010060 A5010061 A5010062 A5010063 A5010064 A5010065 A5010066 A5010067
A5010068 A5010069 A501006A A501006B A501006C A501006D A501006E A501006F
A5010070 A5010071 A5010072 A5010073 A5010074 A5010075 A5010076 A5010077
A5010078 A5010079 A501007A A501007B A501007C A501007D A501007E A501007F
@440
A5110440 A5110441 A5110442 A5110443 A5110444 A5110445 A5110446 A5110447
A5110448 A5110449 A511044A A511044B A511044C A511044D A511044E A511044F
A5110450 A5110451 A5110452 A5110453 A5110454 A5110455 A5110456 A5110457
A5110458 A5110459 A511045A A511045B A511045C A511045D A511045E A511045F
A5110460 A5110461 A5110462 A5110463 A5110464 A5110465 A5110466 A5110467
A5110468 A5110469 A511046A A511046B A511046C A511046D A511046E A511046F
A5110470 A5110471 A5110472 A5110473 A5110474 A5110475 A5110476 A5110477
A5110478 A5110479 A511047A A511047B A511047C A511047D A511047E A511047F
@480
A5120480 A5120481 A5120482 A5120483 A5120484 A5120485 A5120486 A5120487
A5120488 A5120489 A512048A A512048B A512048C A512048D A512048E A512048F
A5120490 A5120491 A5120492 A5120493 A5120494 A5120495 A5120496 A5120497
A5120498 A5120499 A512049A A512049B A512049C A512049D A512049E A512049F
A51204A0 A51204A1 A51204A2 A51204A3 A51204A4 A51204A5 A51204A6 A51204A7
A51204A8 A51204A9 A51204AA A51204AB A51204AC A51204AD A51204AE A51204AF
A51204B0 A51204B1 A51204B2 A51204B3 A51204B4 A51204B5 A51204B6 A51204B7
A51204B8 A51204B9 A51204BA A51204BB A51204BC A51204BD A51204BE A51204BF

// File: build.f
nn_out_pkg.sv
hidden_act_bank.sv
out_read_seq.sv
weight_rom.sv
out_layer_fetch.sv
tb_out_layer_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the output-layer fetch testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_out_layer_fetch \
    -Mdir obj_dir -o sim_out_layer_fetch \
    && ./obj_dir/sim_out_layer_fetch 2>&1 | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q "Regression failed" sim.log && exit 1 || exit 0

// File: tb_out_layer_fetch.sv
// Directed testbench for the output-layer operand fetch
// Expects weights.mem in the working directory, weight cases 0, 1, 17 and 18 are filled

`timescale 1ns/1ps

module tb_out_layer_fetch
    import nn_out_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SWEEP_STEPS    = 2**STEP_WIDTH;

    logic         clk;
    logic         rst_n;
    logic         hidden_wr_en;
    hidden_wr_t   hidden_wr;
    logic         mac_en;
    weight_case_t weight_case;
    mac_operand_t operand;

    // Reference copies of the ROM contents and the activation slots
    weight_t weight_model [2**(CASE_WIDTH + STEP_WIDTH)];
    act_t    shadow [NUM_HIDDEN];

    string current_test;
    int    test_errors;
    int    error_count;
    int    check_count;
    int    tests_run;
    int    tests_failed;
    int    cycle_count;

    out_layer_fetch out_layer_fetch_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .hidden_wr_en (hidden_wr_en),
        .hidden_wr    (hidden_wr),
        .mac_en       (mac_en),
        .weight_case  (weight_case),
        .operand      (operand)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("Regression failed");
        $finish;
    end

    task automatic check_act(input int step_idx, input act_t expected, input act_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("ERROR %s step %0d act: expected %h, actual %h",
                     current_test, step_idx, expected, actual);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic check_weight(input int step_idx, input weight_t expected,
                                input weight_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("ERROR %s step %0d weight: expected %h, actual %h",
                     current_test, step_idx, expected, actual);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errors  = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", current_test);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d mismatches", current_test, test_errors);
        end
    endtask

    task automatic write_slot(input int slot_idx, input act_t data);
        @(posedge clk);
        hidden_wr_en   <= 1'b1;
        hidden_wr.slot <= slot_t'(slot_idx);
        hidden_wr.data <= data;
        shadow[slot_idx] = data;
    endtask

    task automatic stop_writes();
        @(posedge clk);
        hidden_wr_en <= 1'b0;
    endtask

    // Operand for step k is captured at the (k+1)-th edge after mac_en goes high
    task automatic sweep_steps(input weight_case_t wc, input int n_steps);
        int slot_idx;
        int addr;
        @(posedge clk);
        weight_case <= wc;
        mac_en      <= 1'b1;
        for (int k = 0; k < n_steps; k++) begin
            @(posedge clk);
            if (k == n_steps - 1) begin
                mac_en <= 1'b0;
            end
            @(negedge clk);
            slot_idx = (k > NUM_HIDDEN - 1) ? NUM_HIDDEN - 1 : k;
            addr     = int'(wc) * SWEEP_STEPS + k;
            check_act(k, shadow[slot_idx], operand.act);
            check_weight(k, weight_model[addr], operand.weight);
        end
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        sweep_steps(weight_case_t'(0), SWEEP_STEPS);
        finish_test();
    endtask

    task automatic test_full_fill();
        start_test("full_fill");
        for (int s = 0; s < NUM_HIDDEN; s++) begin
            write_slot(s, $urandom());
        end
        stop_writes();
        sweep_steps(weight_case_t'(18), SWEEP_STEPS);
        finish_test();
    endtask

    task automatic test_both_banks();
        start_test("both_banks");
        sweep_steps(weight_case_t'(1), SWEEP_STEPS);
        sweep_steps(weight_case_t'(17), SWEEP_STEPS);
        finish_test();
    endtask

    task automatic test_single_overwrite();
        act_t data;
        start_test("single_overwrite");
        data = $urandom();
        while (data == shadow[23]) begin
            data = $urandom();
        end
        write_slot(23, data);
        stop_writes();
        sweep_steps(weight_case_t'(1), SWEEP_STEPS);
        finish_test();
    endtask

    task automatic test_restart();
        start_test("restart");
        sweep_steps(weight_case_t'(17), 10);
        // One edge still reads step 10, then the bank parks on slot 0
        repeat (2) @(posedge clk);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_act(0, shadow[0], operand.act);
            check_weight(0, weight_model[17 * SWEEP_STEPS], operand.weight);
        end
        sweep_steps(weight_case_t'(17), SWEEP_STEPS);
        finish_test();
    endtask

    initial begin
        rst_n        = 1'b0;
        hidden_wr_en = 1'b0;
        hidden_wr    = '0;
        mac_en       = 1'b0;
        weight_case  = '0;
        error_count  = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h123));
        for (int i = 0; i < 2**(CASE_WIDTH + STEP_WIDTH); i++) begin
            weight_model[i] = '0;
        end
        $readmemh("weights.mem", weight_model);
        for (int i = 0; i < NUM_HIDDEN; i++) begin
            shadow[i] = '0;
        end

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_state();
        test_full_fill();
        test_both_banks();
        test_single_overwrite();
        test_restart();

        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: out_layer_fetch.sv
// Output-layer operand fetch, one activation and one weight per step
// Operand for step k shows one cycle after step k, with no back-pressure
// weight_case must stay stable for the whole sweep

`timescale 1ns/1ps

module out_layer_fetch
    import nn_out_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         hidden_wr_en,
    input  hidden_wr_t   hidden_wr,
    input  logic         mac_en,
    input  weight_case_t weight_case,
    output mac_operand_t operand
);

    step_t        step;
    weight_addr_t rd_addr;
    act_t         act;
    weight_t      weight;

    out_read_seq out_read_seq_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .mac_en      (mac_en),
        .weight_case (weight_case),
        .step        (step),
        .rd_addr     (rd_addr)
    );

    hidden_act_bank hidden_act_bank_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (hidden_wr_en),
        .wr    (hidden_wr),
        .step  (step),
        .act   (act)
    );

    weight_rom weight_rom_i (
        .clk     (clk),
        .rd_addr (rd_addr),
        .weight  (weight)
    );

    // Both halves come out of one-cycle registers, so they stay aligned
    assign operand.act    = act;
    assign operand.weight = weight;

endmodule

// File: weight_rom.sv
// Two-bank output weight ROM, one cycle read latency, no reset
// Contents come from weights.mem, words it does not name read as zero
// Bank select is registered with the data so both belong to the same address

`timescale 1ns/1ps

module weight_rom
    import nn_out_pkg::*;
(
    input  logic         clk,
    input  weight_addr_t rd_addr,
    output weight_t      weight
);

    weight_t bank_lo [ROM_BANK_DEPTH];
    weight_t bank_hi [ROM_BANK_DEPTH];

    // Flat load image, split into the two banks below
    weight_t rom_image [2**WEIGHT_ADDR_WIDTH];

    logic [ROM_INDEX_WIDTH-1:0] rom_index;
    logic                       bank_sel;
    weight_t                    lo_q;
    weight_t                    hi_q;
    logic                       bank_q;

    initial begin
        for (int i = 0; i < 2**WEIGHT_ADDR_WIDTH; i++) begin
            rom_image[i] = '0;
        end
        $readmemh("weights.mem", rom_image);
        for (int i = 0; i < ROM_BANK_DEPTH; i++) begin
            bank_lo[i] = rom_image[i];
            bank_hi[i] = rom_image[i + ROM_BANK_DEPTH];
        end
    end

    assign rom_index = rd_addr[ROM_INDEX_WIDTH-1:0];
    assign bank_sel  = rd_addr[WEIGHT_ADDR_WIDTH-1];

    always_ff @(posedge clk) begin
        lo_q   <= bank_lo[rom_index];
        hi_q   <= bank_hi[rom_index];
        bank_q <= bank_sel;
    end

    assign weight = bank_q ? hi_q : lo_q;

    // Once the sequencer drives a clean address it must stay clean
    a_addr_known: assert property (
        @(posedge clk)
        !$isunknown($past(rd_addr)) |-> !$isunknown(rd_addr)
    );

endmodule

// File: out_read_seq.sv
// Read sequencer for the output layer
// mac_en must be held high for a whole sweep, the step wraps from 63 to 0

`timescale 1ns/1ps

module out_read_seq
    import nn_out_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         mac_en,
    input  weight_case_t weight_case,
    output step_t        step,
    output weight_addr_t rd_addr
);

    // Counts while enabled, parks at 0 otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= '0;
        end else if (mac_en) begin
            step <= step + step_t'(1);
        end else begin
            step <= '0;
        end
    end

    // Address follows the current step
    always_comb begin
        rd_addr.weight_case = weight_case;
        rd_addr.step        = step;
    end

    // Dropping the enable always restarts the next sweep at slot 0
    a_idle_clears_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        !mac_en |=> (step == '0)
    );

endmodule

// File: hidden_act_bank.sv
// Hidden-layer activation bank with one write port and one registered read port
// Steps past the last slot read the last slot again
// A write and a read of the same slot at one edge return the old value

`timescale 1ns/1ps

module hidden_act_bank
    import nn_out_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  hidden_wr_t wr,
    input  step_t      step,
    output act_t       act
);

    act_t                  slots [NUM_HIDDEN];
    logic [NUM_HIDDEN-1:0] slot_we;
    slot_t                 rd_slot;

    // One-hot write decode from the slot index
    always_comb begin
        for (int i = 0; i < NUM_HIDDEN; i++) begin
            slot_we[i] = wr_en && (wr.slot == slot_t'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_HIDDEN; i++) begin
                slots[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_HIDDEN; i++) begin
                if (slot_we[i]) begin
                    slots[i] <= wr.data;
                end
            end
        end
    end

    // Steps 59 to 63 all land on the last slot
    assign rd_slot = (step > step_t'(LAST_SLOT)) ? slot_t'(LAST_SLOT) : slot_t'(step);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act <= '0;
        end else begin
            act <= slots[rd_slot];
        end
    end

    // Writer must stay inside the bank, the decode drops anything beyond it
    a_wr_slot_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr.slot < slot_t'(NUM_HIDDEN))
    );

endmodule

// File: nn_out_pkg.sv
// Shared widths and payload types of the output-layer operand fetch
// The step counter spans 64 steps, and only the first 60 map to real slots

package nn_out_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int NUM_HIDDEN     = 60;
    localparam int STEP_WIDTH     = 6;
    localparam int CASE_WIDTH     = 5;
    localparam int ROM_BANK_DEPTH = 1024;

    // Derived sizes
    localparam int LAST_SLOT         = NUM_HIDDEN - 1;
    localparam int ROM_INDEX_WIDTH   = $clog2(ROM_BANK_DEPTH);
    localparam int WEIGHT_ADDR_WIDTH = CASE_WIDTH + STEP_WIDTH;

    typedef logic [DATA_WIDTH-1:0] act_t;
    typedef logic [DATA_WIDTH-1:0] weight_t;
    typedef logic [STEP_WIDTH-1:0] slot_t;
    typedef logic [STEP_WIDTH-1:0] step_t;
    typedef logic [CASE_WIDTH-1:0] weight_case_t;

    // Top bit of weight_case picks the ROM bank
    typedef struct packed {
        weight_case_t weight_case;
        step_t        step;
    } weight_addr_t;

    // One activation write into the hidden bank
    typedef struct packed {
        slot_t slot;
        act_t  data;
    } hidden_wr_t;

    // Operand pair handed to the output-layer MAC
    typedef struct packed {
        act_t    act;
        weight_t weight;
    } mac_operand_t;

endpackage
